/* Bender.yml */
package:
  name: mips_pipeline

sources:
  - src/cpu_pkg.sv
  - src/instr_decoder.sv
  - src/reg_file.sv
  - src/hazard_unit.sv
  - src/forward_unit.sv
  - src/execute_unit.sv
  - src/cpu_top.sv
  - target: test
    files:
      - testbench/tb_cpu_top.sv

/* compile.f */
src/cpu_pkg.sv
src/instr_decoder.sv
src/reg_file.sv
src/hazard_unit.sv
src/forward_unit.sv
src/execute_unit.sv
src/cpu_top.sv
testbench/tb_cpu_top.sv

/* src/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imm_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_t;

    // Next PC source
    typedef enum logic [1:0] {
        PC_SEQ    = 2'd0,
        PC_JUMP   = 2'd1,
        PC_BRANCH = 2'd2,
        PC_HOLD   = 2'd3
    } pc_sel_t;

    // EX operand source
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_t;

    localparam word_t RESET_PC = 32'h0000_0000;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

`default_nettype wire

/* src/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic           clk,
    input  logic           rst_n_i,
    input  cpu_pkg::word_t ic_data_i,
    input  cpu_pkg::word_t dc_rdata_i,
    input  logic           mem_stall_i,
    output cpu_pkg::word_t ic_addr_o,
    output cpu_pkg::word_t dc_addr_o,
    output logic           dc_read_o,
    output logic           dc_write_o,
    output cpu_pkg::word_t dc_wdata_o
);

    cpu_pkg::word_t     pc, pc_plus4, jump_target;
    cpu_pkg::word_t     ifid_instr, ifid_pc_plus4;
    cpu_pkg::reg_addr_t id_rs, id_rt, id_dest;
    cpu_pkg::word_t     id_imm_ext, id_rs_data, id_rt_data;
    cpu_pkg::alu_op_t   id_alu_op;
    logic               id_use_imm, id_reg_write, id_mem_read, id_mem_write;
    logic               id_branch, id_branch_ne, id_jump;
    cpu_pkg::reg_addr_t idex_rs, idex_rt, idex_dest;
    cpu_pkg::word_t     idex_rs_data, idex_rt_data, idex_imm_ext, idex_pc_plus4;
    cpu_pkg::alu_op_t   idex_alu_op;
    logic               idex_use_imm, idex_reg_write, idex_mem_read, idex_mem_write;
    logic               idex_branch, idex_branch_ne, idex_bubble;
    cpu_pkg::fwd_sel_t  fwd_a, fwd_b;
    cpu_pkg::word_t     op_a, op_b, ex_result, ex_branch_target;
    logic               ex_equal;
    cpu_pkg::reg_addr_t exmem_dest, memwb_dest;
    cpu_pkg::word_t     exmem_result, exmem_store_data, exmem_branch_target;
    logic               exmem_reg_write, exmem_mem_read, exmem_mem_write, exmem_branch_taken;
    cpu_pkg::word_t     memwb_result, memwb_load_data, wb_data;
    logic               memwb_reg_write, memwb_mem_read;
    logic               freeze, stall_ifid, flush_ifid, flush_idex;
    cpu_pkg::pc_sel_t   pc_sel;

    //////////////////////////////////////////////////
    // Fetch
    //////////////////////////////////////////////////

    assign pc_plus4  = pc + 32'd4;
    assign ic_addr_o = pc;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc <= cpu_pkg::RESET_PC;
        end else begin
            case (pc_sel)
                cpu_pkg::PC_SEQ:    pc <= pc_plus4;
                cpu_pkg::PC_JUMP:   pc <= jump_target;
                cpu_pkg::PC_BRANCH: pc <= exmem_branch_target;
                default:            pc <= pc;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze && !stall_ifid) begin
            ifid_pc_plus4 <= pc_plus4;
            ifid_instr    <= flush_ifid ? '0 : ic_data_i;
        end
        if (!rst_n_i) begin
            ifid_instr <= '0;
        end
    end

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    assign jump_target = {ifid_pc_plus4[31:28], ifid_instr[25:0], 2'b00};

    instr_decoder u_decoder (
        .instr_i     (ifid_instr),
        .rs_o        (id_rs),
        .rt_o        (id_rt),
        .dest_o      (id_dest),
        .imm_ext_o   (id_imm_ext),
        .alu_op_o    (id_alu_op),
        .use_imm_o   (id_use_imm),
        .reg_write_o (id_reg_write),
        .mem_read_o  (id_mem_read),
        .mem_write_o (id_mem_write),
        .branch_o    (id_branch),
        .branch_ne_o (id_branch_ne),
        .jump_o      (id_jump)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .rs_addr_i (id_rs),
        .rt_addr_i (id_rt),
        .wr_en_i   (memwb_reg_write),
        .wr_addr_i (memwb_dest),
        .wr_data_i (wb_data),
        .rs_data_o (id_rs_data),
        .rt_data_o (id_rt_data)
    );

    hazard_unit u_hazard (
        .mem_stall_i        (mem_stall_i),
        .id_rs_i            (id_rs),
        .id_rt_i            (id_rt),
        .ex_mem_read_i      (idex_mem_read),
        .ex_dest_i          (idex_dest),
        .id_jump_i          (id_jump),
        .mem_branch_taken_i (exmem_branch_taken),
        .freeze_o           (freeze),
        .stall_ifid_o       (stall_ifid),
        .flush_ifid_o       (flush_ifid),
        .flush_idex_o       (flush_idex),
        .pc_sel_o           (pc_sel)
    );

    // Squashed or interlocked slot enters EX as a bubble
    assign idex_bubble = flush_idex || stall_ifid;

    always_ff @(posedge clk) begin
        if (!freeze) begin
            idex_rs        <= id_rs;
            idex_rt        <= id_rt;
            idex_dest      <= id_dest;
            idex_rs_data   <= id_rs_data;
            idex_rt_data   <= id_rt_data;
            idex_imm_ext   <= id_imm_ext;
            idex_pc_plus4  <= ifid_pc_plus4;
            idex_alu_op    <= id_alu_op;
            idex_use_imm   <= id_use_imm;
            idex_reg_write <= id_reg_write && !idex_bubble;
            idex_mem_read  <= id_mem_read && !idex_bubble;
            idex_mem_write <= id_mem_write && !idex_bubble;
            idex_branch    <= id_branch && !idex_bubble;
            idex_branch_ne <= id_branch_ne;
        end
        if (!rst_n_i) begin
            idex_reg_write <= 1'b0;
            idex_mem_read  <= 1'b0;
            idex_mem_write <= 1'b0;
            idex_branch    <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////

    forward_unit u_forward (
        .ex_rs_i         (idex_rs),
        .ex_rt_i         (idex_rt),
        .mem_dest_i      (exmem_dest),
        .mem_reg_write_i (exmem_reg_write),
        .wb_dest_i       (memwb_dest),
        .wb_reg_write_i  (memwb_reg_write),
        .fwd_a_o         (fwd_a),
        .fwd_b_o         (fwd_b)
    );

    function automatic cpu_pkg::word_t fwd_mux(
        input cpu_pkg::fwd_sel_t sel,
        input cpu_pkg::word_t    reg_val,
        input cpu_pkg::word_t    mem_val,
        input cpu_pkg::word_t    wb_val
    );
        case (sel)
            cpu_pkg::FWD_MEM: return mem_val;
            cpu_pkg::FWD_WB:  return wb_val;
            default:          return reg_val;
        endcase
    endfunction

    assign op_a = fwd_mux(fwd_a, idex_rs_data, exmem_result, wb_data);
    assign op_b = fwd_mux(fwd_b, idex_rt_data, exmem_result, wb_data);

    execute_unit u_execute (
        .op_a_i          (op_a),
        .op_b_i          (op_b),
        .imm_ext_i       (idex_imm_ext),
        .pc_plus4_i      (idex_pc_plus4),
        .alu_op_i        (idex_alu_op),
        .use_imm_i       (idex_use_imm),
        .result_o        (ex_result),
        .branch_target_o (ex_branch_target),
        .equal_o         (ex_equal)
    );

    always_ff @(posedge clk) begin
        if (!freeze) begin
            exmem_dest          <= idex_dest;
            exmem_result        <= ex_result;
            exmem_store_data    <= op_b;
            exmem_branch_target <= ex_branch_target;
            exmem_reg_write     <= idex_reg_write;
            exmem_mem_read      <= idex_mem_read;
            exmem_mem_write     <= idex_mem_write;
            exmem_branch_taken  <= idex_branch && (ex_equal != idex_branch_ne);
        end
        if (!rst_n_i) begin
            exmem_reg_write    <= 1'b0;
            exmem_mem_read     <= 1'b0;
            exmem_mem_write    <= 1'b0;
            exmem_branch_taken <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Memory and writeback
    //////////////////////////////////////////////////

    assign dc_addr_o  = exmem_result;
    assign dc_wdata_o = exmem_store_data;
    assign dc_read_o  = exmem_mem_read;
    assign dc_write_o = exmem_mem_write;

    always_ff @(posedge clk) begin
        if (!freeze) begin
            memwb_dest      <= exmem_dest;
            memwb_result    <= exmem_result;
            memwb_load_data <= dc_rdata_i;
            memwb_reg_write <= exmem_reg_write;
            memwb_mem_read  <= exmem_mem_read;
        end
        if (!rst_n_i) begin
            memwb_reg_write <= 1'b0;
            memwb_mem_read  <= 1'b0;
        end
    end

    assign wb_data = memwb_mem_read ? memwb_load_data : memwb_result;

endmodule

`default_nettype wire

/* src/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  cpu_pkg::word_t   op_a_i,
    input  cpu_pkg::word_t   op_b_i,
    input  cpu_pkg::word_t   imm_ext_i,
    input  cpu_pkg::word_t   pc_plus4_i,
    input  cpu_pkg::alu_op_t alu_op_i,
    input  logic             use_imm_i,
    output cpu_pkg::word_t   result_o,
    output cpu_pkg::word_t   branch_target_o,
    output logic             equal_o
);

    cpu_pkg::word_t alu_b;

    assign alu_b = use_imm_i ? imm_ext_i : op_b_i;

    always_comb begin
        case (alu_op_i)
            cpu_pkg::ALU_SUB: result_o = op_a_i - alu_b;
            cpu_pkg::ALU_AND: result_o = op_a_i & alu_b;
            cpu_pkg::ALU_OR:  result_o = op_a_i | alu_b;
            cpu_pkg::ALU_SLT: result_o = {31'b0, $signed(op_a_i) < $signed(alu_b)};
            default:          result_o = op_a_i + alu_b;
        endcase
    end

    // Branch compare always uses both registers
    assign equal_o         = (op_a_i == op_b_i);
    assign branch_target_o = pc_plus4_i + {imm_ext_i[29:0], 2'b00};

endmodule

`default_nettype wire

/* src/forward_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module forward_unit (
    input  cpu_pkg::reg_addr_t ex_rs_i,
    input  cpu_pkg::reg_addr_t ex_rt_i,
    input  cpu_pkg::reg_addr_t mem_dest_i,
    input  logic               mem_reg_write_i,
    input  cpu_pkg::reg_addr_t wb_dest_i,
    input  logic               wb_reg_write_i,
    output cpu_pkg::fwd_sel_t  fwd_a_o,
    output cpu_pkg::fwd_sel_t  fwd_b_o
);

    // Youngest producer wins
    // r0 writes never reach here
    function automatic cpu_pkg::fwd_sel_t pick_source(input cpu_pkg::reg_addr_t src);
        if (mem_reg_write_i && (mem_dest_i == src)) begin
            return cpu_pkg::FWD_MEM;
        end
        if (wb_reg_write_i && (wb_dest_i == src)) begin
            return cpu_pkg::FWD_WB;
        end
        return cpu_pkg::FWD_REG;
    endfunction

    always_comb begin
        fwd_a_o = pick_source(ex_rs_i);
        fwd_b_o = pick_source(ex_rt_i);
    end

endmodule

`default_nettype wire

/* src/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  logic               mem_stall_i,
    input  cpu_pkg::reg_addr_t id_rs_i,
    input  cpu_pkg::reg_addr_t id_rt_i,
    input  logic               ex_mem_read_i,
    input  cpu_pkg::reg_addr_t ex_dest_i,
    input  logic               id_jump_i,
    input  logic               mem_branch_taken_i,
    output logic               freeze_o,
    output logic               stall_ifid_o,
    output logic               flush_ifid_o,
    output logic               flush_idex_o,
    output cpu_pkg::pc_sel_t   pc_sel_o
);

    logic load_use;

    // Load in EX feeding the instruction in ID
    assign load_use = ex_mem_read_i && (ex_dest_i != '0) &&
                      ((ex_dest_i == id_rs_i) || (ex_dest_i == id_rt_i));

    assign freeze_o     = mem_stall_i;
    assign flush_ifid_o = mem_branch_taken_i;
    assign flush_idex_o = mem_branch_taken_i;
    // The ID instruction is squashed anyway on a taken branch
    assign stall_ifid_o = load_use && !mem_branch_taken_i;

    always_comb begin
        if (mem_stall_i) begin
            pc_sel_o = cpu_pkg::PC_HOLD;
        end else if (mem_branch_taken_i) begin
            pc_sel_o = cpu_pkg::PC_BRANCH;
        end else if (load_use) begin
            pc_sel_o = cpu_pkg::PC_HOLD;
        end else if (id_jump_i) begin
            pc_sel_o = cpu_pkg::PC_JUMP;
        end else begin
            pc_sel_o = cpu_pkg::PC_SEQ;
        end
    end

endmodule

`default_nettype wire

/* src/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  cpu_pkg::word_t     instr_i,
    output cpu_pkg::reg_addr_t rs_o,
    output cpu_pkg::reg_addr_t rt_o,
    output cpu_pkg::reg_addr_t dest_o,
    output cpu_pkg::word_t     imm_ext_o,
    output cpu_pkg::alu_op_t   alu_op_o,
    output logic               use_imm_o,
    output logic               reg_write_o,
    output logic               mem_read_o,
    output logic               mem_write_o,
    output logic               branch_o,
    output logic               branch_ne_o,
    output logic               jump_o
);

    logic [5:0]         opcode;
    logic [5:0]         funct;
    cpu_pkg::imm_t      imm;
    cpu_pkg::reg_addr_t rd;
    logic               writes_reg;

    assign opcode    = instr_i[31:26];
    assign rs_o      = instr_i[25:21];
    assign rt_o      = instr_i[20:16];
    assign rd        = instr_i[15:11];
    assign funct     = instr_i[5:0];
    assign imm       = instr_i[15:0];
    assign imm_ext_o = {{16{imm[15]}}, imm};

    always_comb begin
        alu_op_o    = cpu_pkg::ALU_ADD;
        dest_o      = rd;
        use_imm_o   = 1'b0;
        writes_reg  = 1'b0;
        mem_read_o  = 1'b0;
        mem_write_o = 1'b0;
        branch_o    = 1'b0;
        branch_ne_o = 1'b0;
        jump_o      = 1'b0;
        case (opcode)
            cpu_pkg::OP_RTYPE: begin
                writes_reg = 1'b1;
                case (funct)
                    cpu_pkg::FN_ADDU: alu_op_o = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUBU: alu_op_o = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND:  alu_op_o = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:   alu_op_o = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_SLT:  alu_op_o = cpu_pkg::ALU_SLT;
                    default:          writes_reg = 1'b0;
                endcase
            end
            cpu_pkg::OP_ADDIU: begin
                dest_o     = rt_o;
                use_imm_o  = 1'b1;
                writes_reg = 1'b1;
            end
            cpu_pkg::OP_LW: begin
                dest_o     = rt_o;
                use_imm_o  = 1'b1;
                writes_reg = 1'b1;
                mem_read_o = 1'b1;
            end
            cpu_pkg::OP_SW: begin
                use_imm_o   = 1'b1;
                mem_write_o = 1'b1;
            end
            cpu_pkg::OP_BEQ: branch_o = 1'b1;
            cpu_pkg::OP_BNE: begin
                branch_o    = 1'b1;
                branch_ne_o = 1'b1;
            end
            cpu_pkg::OP_J: jump_o = 1'b1;
            default: ;
        endcase
    end

    // r0 is never written
    assign reg_write_o = writes_reg && (dest_o != '0);

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               rst_n_i,
    input  cpu_pkg::reg_addr_t rs_addr_i,
    input  cpu_pkg::reg_addr_t rt_addr_i,
    input  logic               wr_en_i,
    input  cpu_pkg::reg_addr_t wr_addr_i,
    input  cpu_pkg::word_t     wr_data_i,
    output cpu_pkg::word_t     rs_data_o,
    output cpu_pkg::word_t     rt_data_o
);

    cpu_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // Same-cycle write shows up on the read side
    function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en_i && (wr_addr_i == addr)) begin
            return wr_data_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs_data_o = read_port(rs_addr_i);
        rt_data_o = read_port(rt_addr_i);
    end

endmodule

`default_nettype wire

/* testbench/tb_cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

    localparam int             CLK_PERIOD  = 4;
    localparam int             BODY_LEN    = 64;
    localparam int             IMEM_WORDS  = 128;
    localparam int             LOOP_INDEX  = BODY_LEN + 31;
    localparam cpu_pkg::word_t LOOP_ADDR   = LOOP_INDEX * 4;
    localparam int             WATCHDOG_NS = (BODY_LEN + 31 + 20) * 4 * CLK_PERIOD;

    logic           clk = 1'b0;
    logic           rst_n_i;
    logic           mem_stall_i;
    cpu_pkg::word_t ic_data_i;
    cpu_pkg::word_t dc_rdata_i;
    cpu_pkg::word_t ic_addr_o;
    cpu_pkg::word_t dc_addr_o;
    logic           dc_read_o;
    logic           dc_write_o;
    cpu_pkg::word_t dc_wdata_o;

    cpu_pkg::word_t imem [IMEM_WORDS];
    cpu_pkg::word_t dmem [64];
    cpu_pkg::word_t model_ram [64];
    cpu_pkg::word_t model_regs [32];
    cpu_pkg::word_t exp_addr [$];
    cpu_pkg::word_t exp_data [$];
    cpu_pkg::word_t exp_load [$];
    logic [15:0]    lfsr_state = 16'd42855;
    int             model_stores = 0;
    int             stores_seen = 0;
    int             model_loads = 0;
    int             loads_seen = 0;

    cpu_top DUT (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ic_data_i   (ic_data_i),
        .dc_rdata_i  (dc_rdata_i),
        .mem_stall_i (mem_stall_i),
        .ic_addr_o   (ic_addr_o),
        .dc_addr_o   (dc_addr_o),
        .dc_read_o   (dc_read_o),
        .dc_write_o  (dc_write_o),
        .dc_wdata_o  (dc_wdata_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Both memories answer in the same cycle
    assign ic_data_i  = imem[ic_addr_o[8:2]];
    assign dc_rdata_i = dmem[dc_addr_o[7:2]];

    always @(posedge clk) begin
        if (dc_write_o && !mem_stall_i) begin
            dmem[dc_addr_o[7:2]] <= dc_wdata_o;
        end
    end

    //////////////////////////////////////////////////
    // Random numbers and instruction encoding
    //////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    function automatic int unsigned take_bits(input int n);
        int unsigned value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | lfsr_state[0];
        end
        return value;
    endfunction

    function automatic cpu_pkg::reg_addr_t pick_reg();
        return cpu_pkg::reg_addr_t'(1 + take_bits(3) % 7);
    endfunction

    function automatic logic [5:0] funct_code(input int n);
        case (n)
            0:       return cpu_pkg::FN_ADDU;
            1:       return cpu_pkg::FN_SUBU;
            2:       return cpu_pkg::FN_AND;
            3:       return cpu_pkg::FN_OR;
            default: return cpu_pkg::FN_SLT;
        endcase
    endfunction

    function automatic cpu_pkg::word_t rtype_word(
        input logic [5:0]         fn,
        input cpu_pkg::reg_addr_t rd,
        input cpu_pkg::reg_addr_t rs,
        input cpu_pkg::reg_addr_t rt
    );
        return {cpu_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic cpu_pkg::word_t itype_word(
        input logic [5:0]         op,
        input cpu_pkg::reg_addr_t rs,
        input cpu_pkg::reg_addr_t rt,
        input cpu_pkg::imm_t      imm
    );
        return {op, rs, rt, imm};
    endfunction

    function automatic cpu_pkg::word_t jump_word(input logic [25:0] index);
        return {cpu_pkg::OP_J, index};
    endfunction

    function automatic cpu_pkg::word_t fill_word(input int index);
        return 32'h5EED_0000 ^ (index * 32'h0001_0003);
    endfunction

    task automatic build_program();
        int                 kind;
        logic               prev_ctrl;
        cpu_pkg::reg_addr_t ra, rb, rc;
        prev_ctrl = 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = '0;
        end
        // Forwarding chain, load-use pair and a taken BEQ that skips index 8
        imem[0] = itype_word(cpu_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h1234);
        imem[1] = itype_word(cpu_pkg::OP_ADDIU, 5'd1, 5'd2, 16'h0011);
        imem[2] = rtype_word(cpu_pkg::FN_ADDU, 5'd3, 5'd1, 5'd2);
        imem[3] = itype_word(cpu_pkg::OP_SW, 5'd0, 5'd3, 16'h0000);
        imem[4] = itype_word(cpu_pkg::OP_LW, 5'd0, 5'd4, 16'h0000);
        imem[5] = rtype_word(cpu_pkg::FN_SUBU, 5'd5, 5'd4, 5'd1);
        imem[6] = itype_word(cpu_pkg::OP_BEQ, 5'd4, 5'd3, 16'd2);
        imem[7] = rtype_word(cpu_pkg::FN_OR, 5'd6, 5'd4, 5'd5);
        imem[8] = itype_word(cpu_pkg::OP_ADDIU, 5'd0, 5'd7, 16'h7777);
        imem[9] = itype_word(cpu_pkg::OP_SW, 5'd0, 5'd6, 16'h0004);
        for (int i = 10; i < BODY_LEN; i++) begin
            kind = take_bits(3);
            ra = pick_reg();
            rb = pick_reg();
            rc = pick_reg();
            // No control transfer in a delay slot or near the end of the body
            if ((kind == 5 || kind == 6) && (prev_ctrl || i >= BODY_LEN - 6)) begin
                kind = 2;
            end
            prev_ctrl = (kind == 5) || (kind == 6);
            case (kind)
                2: imem[i] = itype_word(cpu_pkg::OP_ADDIU, ra, rb,
                                        cpu_pkg::imm_t'(take_bits(16)));
                3: imem[i] = itype_word(cpu_pkg::OP_LW, 5'd0, rb,
                                        cpu_pkg::imm_t'(4 * take_bits(5)));
                4: imem[i] = itype_word(cpu_pkg::OP_SW, 5'd0, rb,
                                        cpu_pkg::imm_t'(4 * take_bits(5)));
                5: imem[i] = itype_word(take_bits(1) ? cpu_pkg::OP_BNE : cpu_pkg::OP_BEQ,
                                        ra, rb, cpu_pkg::imm_t'(1 + take_bits(2) % 3));
                6: imem[i] = jump_word(i + 2 + take_bits(2) % 3);
                default: imem[i] = rtype_word(funct_code(take_bits(3) % 5), rc, ra, rb);
            endcase
        end
        // Register dump into the upper words
        for (int r = 1; r < 32; r++) begin
            imem[BODY_LEN + r - 1] = itype_word(cpu_pkg::OP_SW, 5'd0, cpu_pkg::reg_addr_t'(r),
                                                cpu_pkg::imm_t'(4 * (31 + r)));
        end
        imem[LOOP_INDEX] = jump_word(LOOP_INDEX);
    endtask

    //////////////////////////////////////////////////
    // ISA model
    //////////////////////////////////////////////////

    task automatic run_model();
        cpu_pkg::word_t     pc, npc, nnpc, seq, ins, a, b, ext, addr, wr_val;
        cpu_pkg::reg_addr_t wr_reg;
        int                 steps;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int w = 0; w < 64; w++) begin
            model_ram[w] = fill_word(w);
        end
        pc = cpu_pkg::RESET_PC;
        npc = pc + 32'd4;
        steps = 0;
        while ((pc != LOOP_ADDR) && (steps < 1000)) begin
            ins = imem[pc[8:2]];
            a = model_regs[ins[25:21]];
            b = model_regs[ins[20:16]];
            ext = {{16{ins[15]}}, ins[15:0]};
            addr = a + ext;
            seq = pc + 32'd4;
            nnpc = npc + 32'd4;
            wr_reg = '0;
            wr_val = '0;
            case (ins[31:26])
                cpu_pkg::OP_RTYPE: begin
                    wr_reg = ins[15:11];
                    case (ins[5:0])
                        cpu_pkg::FN_ADDU: wr_val = a + b;
                        cpu_pkg::FN_SUBU: wr_val = a - b;
                        cpu_pkg::FN_AND:  wr_val = a & b;
                        cpu_pkg::FN_OR:   wr_val = a | b;
                        cpu_pkg::FN_SLT:  wr_val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:          wr_reg = '0;
                    endcase
                end
                cpu_pkg::OP_ADDIU: begin
                    wr_reg = ins[20:16];
                    wr_val = addr;
                end
                cpu_pkg::OP_LW: begin
                    wr_reg = ins[20:16];
                    wr_val = model_ram[addr[7:2]];
                    exp_load.push_back(addr);
                end
                cpu_pkg::OP_SW: begin
                    model_ram[addr[7:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                cpu_pkg::OP_BEQ: if (a == b) nnpc = seq + {ext[29:0], 2'b00};
                cpu_pkg::OP_BNE: if (a != b) nnpc = seq + {ext[29:0], 2'b00};
                cpu_pkg::OP_J:   nnpc = {seq[31:28], ins[25:0], 2'b00};
                default: ;
            endcase
            if (wr_reg != '0) begin
                model_regs[wr_reg] = wr_val;
            end
            // The delay slot runs before the redirect
            pc = npc;
            npc = nnpc;
            steps++;
        end
        if (pc != LOOP_ADDR) begin
            abort_run("Reference model did not reach the final loop");
        end
        model_stores = exp_addr.size();
        model_loads = exp_load.size();
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_addr(input string name, input cpu_pkg::word_t exp,
                              input cpu_pkg::word_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED at %0t ns: %s expected 0x%08h, got 0x%08h",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input cpu_pkg::word_t exp,
                              input cpu_pkg::word_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED at %0t ns: %s expected 0x%08h, got 0x%08h",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_strobe(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED at %0t ns: %s expected %b, got %b",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("FAILED at %0t ns: %s expected %0d, got %0d",
                                $time, name, exp, act));
        end
    endtask

    task automatic compare_store();
        cpu_pkg::word_t want_addr, want_data;
        if (exp_addr.size() == 0) begin
            abort_run("The CPU made a store after the expected store list was used up");
        end
        want_addr = exp_addr.pop_front();
        want_data = exp_data.pop_front();
        check_addr("dc_addr_o", want_addr, dc_addr_o);
        check_data("dc_wdata_o", want_data, dc_wdata_o);
        stores_seen++;
    endtask

    task automatic compare_load();
        cpu_pkg::word_t want_addr;
        if (exp_load.size() == 0) begin
            abort_run("The CPU made a load after the expected load list was used up");
        end
        want_addr = exp_load.pop_front();
        check_addr("dc_addr_o", want_addr, dc_addr_o);
        loads_seen++;
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        int   loop_entries;
        logic at_loop;
        loop_entries = 0;
        at_loop = 1'b0;
        rst_n_i = 1'b0;
        mem_stall_i = 1'b0;
        build_program();
        for (int w = 0; w < 64; w++) begin
            dmem[w] = fill_word(w);
        end
        run_model();

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_addr("ic_addr_o", cpu_pkg::RESET_PC, ic_addr_o);
        check_strobe("dc_read_o", 1'b0, dc_read_o);
        check_strobe("dc_write_o", 1'b0, dc_write_o);
        rst_n_i = 1'b1;

        // Third arrival at the loop means the register dump has drained
        while (loop_entries < 3) begin
            @(negedge clk);
            mem_stall_i = (take_bits(2) == 0);
            if (dc_write_o && !mem_stall_i) begin
                compare_store();
            end
            if (dc_read_o && !mem_stall_i) begin
                compare_load();
            end
            if ((ic_addr_o == LOOP_ADDR) && !at_loop) begin
                loop_entries++;
            end
            at_loop = (ic_addr_o == LOOP_ADDR);
        end

        check_count("effective store count", model_stores, stores_seen);
        check_count("effective load count", model_loads, loads_seen);
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Timeout: the program did not reach its final loop");
    end

endmodule

`default_nettype wire
